// ==== Makefile ====
SRCS := $(shell cat sim.f)

obj_dir/Vfraise_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module fraise_tb -f sim.f

run: obj_dir/Vfraise_tb
	./obj_dir/Vfraise_tb | tee /dev/stderr | grep -q '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== logic/fraise_array_pkg.sv ====
// geometry of the memristor array and cycle counts of one log inference run
// LANES must be a power of two, the lane number is carried in the top address bits

package fraise_array_pkg;

    localparam int unsigned LANES        = 4;
    localparam int unsigned ARRAY_ADDR_W = 8;   // addr_col / addr_row width

    // one observation read per lane, each split in SL/WL phases
    localparam int unsigned PHASES       = 4;

    localparam int unsigned INF_CYCLES   = 4;
    localparam int unsigned READOUT_WAIT = 4;   // read_out high before first capture
    localparam int unsigned RESULT_BITS  = 8;   // per lane, MSB first on bit_out

endpackage

// ==== logic/fraise_array_sequencer.sv ====
// drives the array pins through one log-mode inference run
// stoch_log is strapped to log outside the chip; no stochastic or write support

`timescale 1ns/10ps

module fraise_array_sequencer (
    input  logic                                         clk_i,
    input  logic                                         counter_read_reset,
    input  logic                                         start_i,
    input  fraise_regs_pkg::obs_word_u                   obs_col_i,
    input  fraise_regs_pkg::obs_word_u                   obs_row_i,
    output logic                                         busy_o,
    output logic                                         run_done_o,
    // result buffer control
    output logic                                         capture_en_o,
    output logic [$clog2(fraise_array_pkg::RESULT_BITS)-1:0] bit_index_o,
    output logic                                         clear_o,
    // array pins
    output logic                                         inference_o,
    output logic                                         read_8_o,
    output logic                                         read_out_o,
    output logic                                         csl_o,
    output logic                                         cwl_o,
    output logic [fraise_array_pkg::ARRAY_ADDR_W-1:0]    addr_col_o,
    output logic [fraise_array_pkg::ARRAY_ADDR_W-1:0]    addr_row_o
);

    localparam int unsigned CNT_W  = $clog2(fraise_array_pkg::RESULT_BITS);
    localparam int unsigned LANE_W = $clog2(fraise_array_pkg::LANES);
    localparam int unsigned COL_W  = 3;  // column field in each obs byte
    localparam int unsigned ROW_W  = 6;  // row field in each obs byte

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,     // observation reads, lane by lane
        S_INF,
        S_WAIT,     // read-out settling
        S_CAPTURE,
        S_DONE
    } state_e;

    state_e              state_q;
    logic [CNT_W-1:0]    cnt_q;     // phase in read, cycle elsewhere
    logic [LANE_W-1:0]   lane_q;
    logic                in_read;
    logic [COL_W-1:0]    col_field;
    logic [ROW_W-1:0]    row_field;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            lane_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    cnt_q  <= '0;
                    lane_q <= '0;
                    if (start_i) begin
                        state_q <= S_READ;
                    end
                end
                S_READ: begin
                    if (cnt_q == CNT_W'(fraise_array_pkg::PHASES - 1)) begin
                        cnt_q <= '0;
                        if (lane_q == LANE_W'(fraise_array_pkg::LANES - 1)) begin
                            lane_q  <= '0;
                            state_q <= S_INF;
                        end else begin
                            lane_q <= lane_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                S_INF: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(fraise_array_pkg::INF_CYCLES - 1)) begin
                        cnt_q   <= '0;
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(fraise_array_pkg::READOUT_WAIT - 1)) begin
                        cnt_q   <= '0;
                        state_q <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(fraise_array_pkg::RESULT_BITS - 1)) begin
                        cnt_q   <= '0;
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;  // S_DONE lasts one cycle
            endcase
        end
    end

    assign in_read = (state_q == S_READ);

    // SL/WL phases: both rise, SL falls, WL held, WL falls
    assign csl_o    = in_read && (cnt_q == '0);
    assign cwl_o    = in_read && (cnt_q != CNT_W'(fraise_array_pkg::PHASES - 1));
    assign read_8_o = in_read;

    assign inference_o = (state_q == S_INF) || (state_q == S_WAIT) || (state_q == S_CAPTURE);
    assign read_out_o  = (state_q == S_WAIT) || (state_q == S_CAPTURE);

    // lane view of the observation words
    assign col_field  = obs_col_i.lanes[lane_q][COL_W-1:0];
    assign row_field  = obs_row_i.lanes[lane_q][ROW_W-1:0];
    assign addr_col_o = in_read ? {lane_q, 3'b000, col_field} : '0;
    assign addr_row_o = in_read ? {2'b00, row_field} : '0;

    assign capture_en_o = (state_q == S_CAPTURE);
    assign bit_index_o  = CNT_W'(fraise_array_pkg::RESULT_BITS - 1) - cnt_q;  // MSB first
    assign clear_o      = start_i && (state_q == S_IDLE);
    assign busy_o       = (state_q != S_IDLE);
    assign run_done_o   = (state_q == S_DONE);

    // front end must hold launches off while the run is going
    a_no_start_busy: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        busy_o |-> !start_i);

    // SL pulse only opens a read, and WL stays up through the next phase
    a_csl_in_read: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        csl_o |-> read_8_o && cwl_o ##1 read_8_o && !csl_o && cwl_o);

endmodule

// ==== logic/fraise_reg_front.sv ====
// bus register front end; requests are plain strobes, no response back-pressure
// requests are refused while a run is busy, the host has to retry

`timescale 1ns/10ps

module fraise_reg_front #(
    parameter int unsigned NbrHostsLog2 = 1
) (
    input  logic                                       clk_i,
    input  logic                                       counter_read_reset,
    // bus request
    input  logic                                       req_valid_i,
    input  logic [NbrHostsLog2-1:0]                    req_host_addr_i,
    input  logic [fraise_regs_pkg::ADDR_WIDTH-1:0]     req_addr_i,
    input  logic                                       req_wen_i,
    input  logic [fraise_regs_pkg::DATA_WIDTH-1:0]     req_wdata_i,
    input  logic [fraise_regs_pkg::DATA_WIDTH/8-1:0]   req_ben_i,
    output logic                                       ready_o,
    // bus response
    output logic                                       resp_valid_o,
    output logic [fraise_regs_pkg::DATA_WIDTH-1:0]     resp_data_o,
    output logic [NbrHostsLog2-1:0]                    resp_ini_addr_o,
    // sequencer side
    input  logic                                       busy_i,
    input  logic                                       run_done_i,
    output logic                                       start_o,
    output fraise_regs_pkg::obs_word_u                 obs_col_o,
    output fraise_regs_pkg::obs_word_u                 obs_row_o,
    // result buffer side
    input  logic [fraise_regs_pkg::DATA_WIDTH-1:0]     result_word_i,
    input  logic                                       result_pending_i,
    output logic                                       result_read_o
);

    logic                                    accept;
    logic                                    wr_acc;
    logic                                    rd_acc;
    logic [fraise_regs_pkg::DATA_WIDTH-1:0]  ben_mask;
    logic [fraise_regs_pkg::DATA_WIDTH-1:0]  rdata;
    logic                                    on_off_q;    // 0 off, 1 on
    fraise_regs_pkg::obs_word_u              obs_col_q;
    fraise_regs_pkg::obs_word_u              obs_row_q;

    assign ready_o = !busy_i;
    assign accept  = req_valid_i && ready_o;
    assign wr_acc  = accept && req_wen_i;
    assign rd_acc  = accept && !req_wen_i;

    // byte enables spread to bit mask
    always_comb begin
        for (int b = 0; b < fraise_regs_pkg::DATA_WIDTH / 8; b++) begin
            ben_mask[8*b +: 8] = {8{req_ben_i[b]}};
        end
    end

    always_comb begin
        rdata = '0;
        case (req_addr_i)
            fraise_regs_pkg::ON_OFF_ADDR:  rdata[0] = on_off_q;
            fraise_regs_pkg::LAUNCH_ADDR:  rdata[0] = result_pending_i;
            fraise_regs_pkg::RESULT_ADDR:  rdata = result_word_i;
            fraise_regs_pkg::OBS_COL_ADDR: rdata = obs_col_q.raw;
            fraise_regs_pkg::OBS_ROW_ADDR: rdata = obs_row_q.raw;
            default:                       rdata = '0;  // unknown address reads 0
        endcase
    end

    // launch only counts while the on/off register is on
    assign start_o = wr_acc && (req_addr_i == fraise_regs_pkg::LAUNCH_ADDR)
                     && req_wdata_i[0] && on_off_q;
    assign result_read_o = rd_acc && (req_addr_i == fraise_regs_pkg::RESULT_ADDR);

    assign obs_col_o = obs_col_q;
    assign obs_row_o = obs_row_q;

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_off_q     <= 1'b0;
            obs_col_q    <= '0;
            obs_row_q    <= '0;
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= accept;
            if (run_done_i) begin
                on_off_q <= 1'b0;  // back to off at end of run
            end else if (wr_acc && req_addr_i == fraise_regs_pkg::ON_OFF_ADDR) begin
                on_off_q <= req_wdata_i[0];
            end
            if (wr_acc && req_addr_i == fraise_regs_pkg::OBS_COL_ADDR) begin
                obs_col_q.raw <= (obs_col_q.raw & ~ben_mask) | (req_wdata_i & ben_mask);
            end
            if (wr_acc && req_addr_i == fraise_regs_pkg::OBS_ROW_ADDR) begin
                obs_row_q.raw <= (obs_row_q.raw & ~ben_mask) | (req_wdata_i & ben_mask);
            end
        end
    end

    // response payload, only meaningful with resp_valid_o
    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_ini_addr_o <= req_host_addr_i;
            resp_data_o     <= req_wen_i ? '0 : rdata;
        end
    end

    // relies on the host leaving a gap between requests
    a_resp_single: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        resp_valid_o |=> !resp_valid_o);

endmodule

// ==== logic/fraise_regs_pkg.sv ====
// register map and bus word layout of the array front end
// all registers are one 32-bit word; the layout assumes DATA_WIDTH stays 32

package fraise_regs_pkg;

    localparam int unsigned DATA_WIDTH = 32;  // one bus word
    localparam int unsigned ADDR_WIDTH = 32;

    // register addresses
    localparam logic [ADDR_WIDTH-1:0] ON_OFF_ADDR  = 32'h0000_0010;  // bit 0 = on
    localparam logic [ADDR_WIDTH-1:0] LAUNCH_ADDR  = 32'h0000_0024;
    localparam logic [ADDR_WIDTH-1:0] RESULT_ADDR  = 32'h0000_0030;  // log result word
    localparam logic [ADDR_WIDTH-1:0] OBS_COL_ADDR = 32'h0000_0034;
    localparam logic [ADDR_WIDTH-1:0] OBS_ROW_ADDR = 32'h0000_0038;

    // observation word, written whole by the bus and read per lane by the array
    // lane n sits in byte n: column field in bits [2:0], row field in bits [5:0]
    typedef union packed {
        logic [DATA_WIDTH-1:0]            raw;
        logic [DATA_WIDTH/8-1:0][7:0]     lanes;
    } obs_word_u;

endpackage

// ==== logic/fraise_result_buffer.sv ====
// collects the captured bit_out samples into the 32-bit log result word
// byte n holds lane n; pending stays set until the host reads the result

`timescale 1ns/10ps

module fraise_result_buffer (
    input  logic                                              clk_i,
    input  logic                                              counter_read_reset,
    input  logic                                              clear_i,
    input  logic                                              capture_en_i,
    input  logic [$clog2(fraise_array_pkg::RESULT_BITS)-1:0]  bit_index_i,
    input  logic [fraise_array_pkg::LANES-1:0]                bit_out_i,
    input  logic                                              result_read_i,
    output logic [fraise_array_pkg::LANES*fraise_array_pkg::RESULT_BITS-1:0] result_word_o,
    output logic                                              result_pending_o
);

    logic [fraise_array_pkg::LANES-1:0][fraise_array_pkg::RESULT_BITS-1:0] bytes_q;
    logic last_capture_q;  // high the cycle after bit 0 was taken

    always_ff @(posedge clk_i) begin
        if (counter_read_reset || clear_i) begin
            bytes_q <= '0;
        end else if (capture_en_i) begin
            for (int l = 0; l < fraise_array_pkg::LANES; l++) begin
                bytes_q[l][bit_index_i] <= bit_out_i[l];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            last_capture_q   <= 1'b0;
            result_pending_o <= 1'b0;
        end else begin
            last_capture_q <= capture_en_i && (bit_index_i == '0);
            if (clear_i) begin
                result_pending_o <= 1'b0;  // new run drops an unread result
            end else if (last_capture_q) begin
                result_pending_o <= 1'b1;
            end else if (result_read_i) begin
                result_pending_o <= 1'b0;
            end
        end
    end

    assign result_word_o = bytes_q;

    a_no_capture_pending: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        capture_en_i |-> !result_pending_o);

endmodule

// ==== logic/fraise_top.sv ====
// front end for the 4-lane memristor Bayesian array, log inference only
// stoch_log is strapped outside the chip; the bus has no response back-pressure

`timescale 1ns/10ps

module fraise_top #(
    parameter int unsigned NbrHostsLog2 = 1  // host address width, 1 or more
) (
    input  logic                                       clk_i,
    input  logic                                       counter_read_reset,
    // bus
    input  logic                                       req_valid_i,
    input  logic [NbrHostsLog2-1:0]                    req_host_addr_i,
    input  logic [fraise_regs_pkg::ADDR_WIDTH-1:0]     req_addr_i,
    input  logic                                       req_wen_i,
    input  logic [fraise_regs_pkg::DATA_WIDTH-1:0]     req_wdata_i,
    input  logic [fraise_regs_pkg::DATA_WIDTH/8-1:0]   req_ben_i,
    output logic                                       ready_o,
    output logic                                       resp_valid_o,
    output logic [fraise_regs_pkg::DATA_WIDTH-1:0]     resp_data_o,
    output logic [NbrHostsLog2-1:0]                    resp_ini_addr_o,
    output logic                                       irq_o,
    // array pins
    output logic                                       inference_o,
    output logic                                       read_8_o,
    output logic                                       read_out_o,
    output logic                                       csl_o,
    output logic                                       cwl_o,
    output logic [fraise_array_pkg::ARRAY_ADDR_W-1:0]  addr_col_o,
    output logic [fraise_array_pkg::ARRAY_ADDR_W-1:0]  addr_row_o,
    input  logic [fraise_array_pkg::LANES-1:0]         bit_out_i
);

    logic                                           start;
    logic                                           busy;
    logic                                           run_done;
    logic                                           clear;
    logic                                           capture_en;
    logic [$clog2(fraise_array_pkg::RESULT_BITS)-1:0] bit_index;
    logic [fraise_regs_pkg::DATA_WIDTH-1:0]         result_word;
    logic                                           result_pending;
    logic                                           result_read;
    fraise_regs_pkg::obs_word_u                     obs_col;
    fraise_regs_pkg::obs_word_u                     obs_row;

    fraise_reg_front #(
        .NbrHostsLog2(NbrHostsLog2)
    ) u_reg_front (
        .clk_i, .counter_read_reset,
        .req_valid_i, .req_host_addr_i, .req_addr_i, .req_wen_i, .req_wdata_i, .req_ben_i,
        .ready_o, .resp_valid_o, .resp_data_o, .resp_ini_addr_o,
        .busy_i           (busy),
        .run_done_i       (run_done),
        .start_o          (start),
        .obs_col_o        (obs_col),
        .obs_row_o        (obs_row),
        .result_word_i    (result_word),
        .result_pending_i (result_pending),
        .result_read_o    (result_read)
    );

    fraise_array_sequencer u_sequencer (
        .clk_i, .counter_read_reset,
        .start_i      (start),
        .obs_col_i    (obs_col),
        .obs_row_i    (obs_row),
        .busy_o       (busy),
        .run_done_o   (run_done),
        .capture_en_o (capture_en),
        .bit_index_o  (bit_index),
        .clear_o      (clear),
        .inference_o, .read_8_o, .read_out_o, .csl_o, .cwl_o, .addr_col_o, .addr_row_o
    );

    fraise_result_buffer u_result_buffer (
        .clk_i, .counter_read_reset,
        .clear_i          (clear),
        .capture_en_i     (capture_en),
        .bit_index_i      (bit_index),
        .bit_out_i,
        .result_read_i    (result_read),
        .result_word_o    (result_word),
        .result_pending_o (result_pending)
    );

    assign irq_o = result_pending;  // high while a result is unread

endmodule

// ==== sim.f ====
logic/fraise_regs_pkg.sv
logic/fraise_array_pkg.sv
logic/fraise_reg_front.sv
logic/fraise_array_sequencer.sv
logic/fraise_result_buffer.sv
logic/fraise_top.sv
tests/tb_clock_gen.sv
tests/tb_array_model.sv
tests/fraise_tb.sv

// ==== tests/fraise_tb.sv ====
// testbench for the log inference front end that stops at the first error
// table rows are applied in order, so each row's readback starts from the last one

`timescale 1ns/10ps

module fraise_tb;

    localparam int unsigned HOST_W      = 2;
    localparam int unsigned ROWS        = 4;
    localparam int unsigned CYCLE_LIMIT = ROWS * 60 + 100;

    logic                clk_i;
    logic                counter_read_reset;
    logic                req_valid_i;
    logic [HOST_W-1:0]   req_host_addr_i;
    logic [31:0]         req_addr_i;
    logic                req_wen_i;
    logic [31:0]         req_wdata_i;
    logic [3:0]          req_ben_i;
    logic                ready_o;
    logic                resp_valid_o;
    logic [31:0]         resp_data_o;
    logic [HOST_W-1:0]   resp_ini_addr_o;
    logic                irq_o;
    logic                inference_o;
    logic                read_8_o;
    logic                read_out_o;
    logic                csl_o;
    logic                cwl_o;
    logic [7:0]          addr_col_o;
    logic [7:0]          addr_row_o;
    logic [3:0]          bit_out_i;

    // stimulus and expected values with one run attempt per row
    logic [31:0] tbl_col [ROWS];
    logic [31:0] tbl_row [ROWS];
    logic [3:0]  tbl_ben [ROWS];
    logic        tbl_on  [ROWS];
    logic [31:0] tbl_exp [ROWS];

    int          seed;
    int unsigned cycles = 0;
    int unsigned run_pos = 0;  // cycles of the current run, 0 when idle

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) u_clock (
        .clk_o (clk_i),
        .rst_o (counter_read_reset)
    );

    fraise_top #(.NbrHostsLog2(HOST_W)) i_dut (
        .clk_i, .counter_read_reset,
        .req_valid_i, .req_host_addr_i, .req_addr_i, .req_wen_i, .req_wdata_i, .req_ben_i,
        .ready_o, .resp_valid_o, .resp_data_o, .resp_ini_addr_o, .irq_o,
        .inference_o, .read_8_o, .read_out_o, .csl_o, .cwl_o, .addr_col_o, .addr_row_o,
        .bit_out_i
    );

    tb_array_model u_array (
        .clk_i,
        .read_8_i   (read_8_o),
        .cwl_i      (cwl_o),
        .read_out_i (read_out_o),
        .addr_col_i (addr_col_o),
        .addr_row_i (addr_row_o),
        .bit_out_o  (bit_out_i)
    );

    function automatic logic [31:0] byte_mask(input logic [3:0] ben);
        logic [31:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{ben[b]}};
        end
        return m;
    endfunction

    // expected log result built from the lane fields of both observation words
    function automatic logic [31:0] log_result(input logic [31:0] col, input logic [31:0] row);
        logic [31:0] r;
        for (int n = 0; n < 4; n++) begin
            r[8*n +: 8] = {row[8*n +: 6], col[8*n +: 2]} ^ (8'(n) * 8'h55);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("error: %s", what);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // pins in cycle pos of a run, 16 read cycles then inference, wait, capture, done
    task automatic check_run_pins(input int unsigned pos);
        logic [4:0] want;  // inference, read_8, read_out, csl, cwl
        want = '0;
        if (pos <= 16) begin
            want[3] = 1'b1;
            want[1] = ((pos - 1) % 4 == 0);
            want[0] = ((pos - 1) % 4 != 3);
        end else if (pos <= 32) begin
            want[4] = 1'b1;
            want[2] = (pos > 20);
        end
        check_value($sformatf("array pins in run cycle %0d", pos), 32'(want),
                    32'({inference_o, read_8_o, read_out_o, csl_o, cwl_o}));
    endtask

    // one request held until ready and then its response is checked
    task automatic bus_request(input logic wen, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] ben,
                               input logic [HOST_W-1:0] host, output logic [31:0] rdata);
        @(posedge clk_i);
        #2;
        req_valid_i     = 1'b1;
        req_wen_i       = wen;
        req_addr_i      = addr;
        req_wdata_i     = wdata;
        req_ben_i       = ben;
        req_host_addr_i = host;
        while (!ready_o) begin
            @(posedge clk_i);
            #2;
            check_true(!resp_valid_o, "response while the request was not accepted");
        end
        @(posedge clk_i);
        #2;
        req_valid_i = 1'b0;
        check_true(resp_valid_o, "no response pulse after an accepted request");
        check_value("response host address", 32'(host), 32'(resp_ini_addr_o));
        rdata = resp_data_o;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] ben, input logic [HOST_W-1:0] host);
        logic [31:0] rdata;
        bus_request(1'b1, addr, wdata, ben, host, rdata);
        check_value("write response data", 32'h0, rdata);
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr,
                               input logic [HOST_W-1:0] host, input logic [31:0] exp);
        logic [31:0] rdata;
        bus_request(1'b0, addr, 32'h0, 4'h0, host, rdata);
        check_value(name, exp, rdata);
    endtask

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    // array pin schedule, sampled mid-cycle
    always @(negedge clk_i) begin
        if (counter_read_reset === 1'b0) begin
            if (!ready_o) begin
                run_pos = run_pos + 1;
                check_run_pins(run_pos);
            end else begin
                if (run_pos != 0) begin
                    check_value("run length in cycles", 32'd33, 32'(run_pos));
                end
                run_pos = 0;
                check_value("array pins while idle", 32'h0,
                            32'({inference_o, read_8_o, read_out_o, csl_o, cwl_o}));
            end
        end
    end

    initial begin
        logic [31:0]       cur_col;
        logic [31:0]       cur_row;
        logic [31:0]       mask;
        logic [HOST_W-1:0] host;

        req_valid_i     = 1'b0;
        req_host_addr_i = '0;
        req_addr_i      = '0;
        req_wen_i       = 1'b0;
        req_wdata_i     = '0;
        req_ben_i       = '0;

        seed    = 54;
        tbl_ben = '{4'hF, 4'h5, 4'hA, 4'h3};
        tbl_on  = '{1'b1, 1'b0, 1'b1, 1'b1};
        cur_col = '0;
        cur_row = '0;
        for (int r = 0; r < ROWS; r++) begin
            tbl_col[r] = $random(seed);
            tbl_row[r] = $random(seed);
            mask       = byte_mask(tbl_ben[r]);
            cur_col    = (cur_col & ~mask) | (tbl_col[r] & mask);
            cur_row    = (cur_row & ~mask) | (tbl_row[r] & mask);
            tbl_exp[r] = log_result(cur_col, cur_row);
        end

        wait (counter_read_reset === 1'b1);
        wait (counter_read_reset === 1'b0);
        check_value("ready after reset", 32'h1, 32'(ready_o));
        check_value("irq and response after reset", 32'h0, 32'({irq_o, resp_valid_o}));
        check_value("array pins after reset", 32'h0,
                    32'({inference_o, read_8_o, read_out_o, csl_o, cwl_o,
                         addr_col_o, addr_row_o}));

        cur_col = '0;
        cur_row = '0;
        for (int r = 0; r < ROWS; r++) begin
            host = HOST_W'(r);
            mask = byte_mask(tbl_ben[r]);
            write_reg(fraise_regs_pkg::OBS_COL_ADDR, tbl_col[r], tbl_ben[r], host);
            cur_col = (cur_col & ~mask) | (tbl_col[r] & mask);
            read_expect($sformatf("row %0d obs_col readback", r),
                        fraise_regs_pkg::OBS_COL_ADDR, host, cur_col);
            write_reg(fraise_regs_pkg::OBS_ROW_ADDR, tbl_row[r], tbl_ben[r], host);
            cur_row = (cur_row & ~mask) | (tbl_row[r] & mask);
            read_expect($sformatf("row %0d obs_row readback", r),
                        fraise_regs_pkg::OBS_ROW_ADDR, host, cur_row);
            write_reg(fraise_regs_pkg::ON_OFF_ADDR, {31'b0, tbl_on[r]}, 4'hF, host);
            write_reg(fraise_regs_pkg::LAUNCH_ADDR, 32'h1, 4'hF, host);
            if (tbl_on[r]) begin
                check_true(!ready_o, "launch while on did not start a run");
                // issued during the run and accepted only once ready returns
                read_expect($sformatf("row %0d on/off after run", r),
                            fraise_regs_pkg::ON_OFF_ADDR, host, 32'h0);
                check_true(irq_o, "irq not raised at the end of the run");
                read_expect($sformatf("row %0d pending flag", r),
                            fraise_regs_pkg::LAUNCH_ADDR, host, 32'h1);
                read_expect($sformatf("row %0d result word", r),
                            fraise_regs_pkg::RESULT_ADDR, host, tbl_exp[r]);
                check_true(!irq_o, "irq still high after the result was read");
            end else begin
                // a run would last 33 cycles and raise irq on the next one
                repeat (34) begin
                    check_true(ready_o, "launch while off started a run");
                    check_true(!irq_o, "irq raised by a launch while off");
                    @(posedge clk_i);
                    #2;
                end
            end
            read_expect($sformatf("row %0d launch register", r),
                        fraise_regs_pkg::LAUNCH_ADDR, host, 32'h0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tests/tb_array_model.sv ====
// behavioral read-out of the memristor array, 4 lanes, log mode only
// lane byte = {row field, column bits [1:0]} ^ (lane * 0x55), sent MSB first

`timescale 1ns/10ps

module tb_array_model (
    input  logic       clk_i,
    input  logic       read_8_i,
    input  logic       cwl_i,
    input  logic       read_out_i,
    input  logic [7:0] addr_col_i,
    input  logic [7:0] addr_row_i,
    output logic [3:0] bit_out_o
);

    logic [7:0] model_byte [4];
    logic       cwl_q;
    logic [3:0] ro_cnt;      // read_out cycles seen so far
    logic [3:0] bit_pos;
    logic [3:0] drive_bits;
    logic [1:0] lane;

    initial begin
        cwl_q     = 1'b0;
        ro_cnt    = 4'd0;
        bit_out_o = 4'd0;
    end

    assign lane    = addr_col_i[7:6];  // lane number in the top column bits
    assign bit_pos = 4'd11 - ro_cnt;

    always @(posedge clk_i) begin
        cwl_q <= cwl_i;
        // WL falling edge closes the lane read
        if (read_8_i && cwl_q && !cwl_i) begin
            model_byte[lane] <= {addr_row_i[5:0], addr_col_i[1:0]} ^ (8'(lane) * 8'h55);
        end
        ro_cnt <= read_out_i ? ro_cnt + 4'd1 : 4'd0;
    end

    always_comb begin
        for (int l = 0; l < 4; l++) begin
            drive_bits[l] = 1'b0;
            if (read_out_i && ro_cnt >= 4'd4 && ro_cnt < 4'd12) begin
                drive_bits[l] = model_byte[l][bit_pos[2:0]];
            end
        end
    end

    always @(posedge clk_i) begin
        #2;
        bit_out_o <= drive_bits;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
// testbench clock and synchronous active-high reset
// reset drops a short delay after the last reset edge, like the other inputs

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 40,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

endmodule
